//--- design/cn_drive_config.svh
`ifndef CN_DRIVE_CONFIG_SVH
`define CN_DRIVE_CONFIG_SVH

// datapath widths
`define CN_DATA_W          32   // currents, gain and drive
`define CN_HOST_W          16   // one host data word
`define CN_TRIG_W          16   // trigger strobe vector

// trigger map
`define CN_TRIG_GAIN       13   // loads the afferent synapse gain

// host register defaults
`define CN_GAIN_RESET      1    // unity gain

// simple synapse
`define CN_SYN_WEIGHT      4000 // current step per presynaptic spike
`define CN_SYN_TAU_SHIFT   3    // leak of current/8 per tick

// drive combiner
`define CN_DRIVE_SHIFT     9    // fixed-point position of the afferent term

// push-button scaler, the code counter walks 2..14 so code>>1 gives 1..7
`define CN_SCALE_W         4
`define CN_SCALE_MIN       2
`define CN_SCALE_MAX       14

// control word
`define CN_CTRL_SIM_RESET  2    // clears synapses and drive

`endif

//--- design/cn_drive_pkg.sv
`include "cn_drive_config.svh"

package cn_drive_pkg;

    // trigger bits decoded by the design, index into the strobe vector
    typedef enum logic [3:0] {
        TRIG_SYN_GAIN = 4'(`CN_TRIG_GAIN)   // {hi, lo} -> afferent gain
    } trig_bit_e;

    // one-cycle presynaptic spike strobes
    typedef struct packed {
        logic ia;   // spindle Ia afferent
        logic ii;   // spindle II afferent
        logic m1a;  // first cortical input
        logic m1b;  // second cortical input, button scaled
    } syn_spikes_t;

    // synaptic currents, same field order as the spikes
    typedef struct packed {
        logic [`CN_DATA_W-1:0] ia;
        logic [`CN_DATA_W-1:0] ii;
        logic [`CN_DATA_W-1:0] m1a;
        logic [`CN_DATA_W-1:0] m1b;
    } syn_currents_t;

    // the two host wire words, hi is the upper half of a 32-bit load
    typedef struct packed {
        logic [`CN_HOST_W-1:0] hi;
        logic [`CN_HOST_W-1:0] lo;
    } host_words_t;

endpackage

//--- design/host_regs.sv
`include "cn_drive_config.svh"

module host_regs
    import cn_drive_pkg::*;
(
    input  logic                  ep50trig,       // simulation tick
    input  logic                  reset_global,
    input  host_words_t           i_host_words,   // data words for triggered loads
    input  logic [`CN_TRIG_W-1:0] i_trig,         // one-cycle load strobes
    input  logic [`CN_HOST_W-1:0] i_ctrl,         // control word, level
    input  logic                  i_ext_reset,    // board reset level
    output logic [`CN_DATA_W-1:0] o_gain,
    output logic                  o_sim_clear
);

    logic [`CN_DATA_W-1:0] gain_q;
    logic                  sim_clear_q;
    logic                  clear_req;     // either clear source, before the flop
    logic                  gain_load;

    // external reset is cleaned through the same flop as the control bit
    assign clear_req = i_ext_reset | i_ctrl[`CN_CTRL_SIM_RESET];
    assign gain_load = i_trig[TRIG_SYN_GAIN];

    // registered simulation clear
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sim_clear_q <= 1'b0;
        end else begin
            sim_clear_q <= clear_req;   // high one tick after either source rises
        end
    end

    // afferent synapse gain, loaded from the two host words
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            gain_q <= `CN_DATA_W'(`CN_GAIN_RESET);   // unity
        end else if (gain_load) begin
            gain_q <= {i_host_words.hi, i_host_words.lo};
        end
    end

    // a sim clear does not touch the gain, only reset_global does

    assign o_gain      = gain_q;
    assign o_sim_clear = sim_clear_q;

endmodule

//--- design/synapse_decay.sv
`include "cn_drive_config.svh"

module synapse_decay #(
    parameter int unsigned WEIGHT    = `CN_SYN_WEIGHT,     // jump per spike
    parameter int unsigned TAU_SHIFT = `CN_SYN_TAU_SHIFT   // leak shift per tick
) (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  i_clear,     // sim clear, zeroes the current
    input  logic                  i_spike,     // presynaptic spike strobe
    output logic [`CN_DATA_W-1:0] o_current
);

    logic [`CN_DATA_W-1:0] current_q;
    logic [`CN_DATA_W-1:0] leak;       // amount lost this tick
    logic [`CN_DATA_W-1:0] kick;       // amount gained this tick
    logic [`CN_DATA_W-1:0] current_d;

    // exponential decay, tau of 2^TAU_SHIFT ticks
    assign leak = current_q >> TAU_SHIFT;
    assign kick = i_spike ? `CN_DATA_W'(WEIGHT) : '0;

    // leak never exceeds the current, so no underflow
    assign current_d = current_q - leak + kick;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            current_q <= '0;
        end else if (i_clear) begin
            current_q <= '0;        // clear wins over a spike
        end else begin
            current_q <= current_d;
        end
    end

    // settles where leak equals weight, about WEIGHT << TAU_SHIFT
    assign o_current = current_q;

endmodule

//--- design/button_scaler.sv
`include "cn_drive_config.svh"

module button_scaler (
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   i_button,    // raw push-button level
    output logic [`CN_SCALE_W-1:0] o_scaler     // multiplier 1..7
);

    logic                   btn_meta;   // first sync stage
    logic                   btn_sync;   // second sync stage
    logic                   btn_change;
    logic [`CN_SCALE_W-1:0] code_q;     // walks MIN..MAX, lsb is a half step

    // two-flop synchronizer, also serves as the edge detector
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= i_button;
            btn_sync <= btn_meta;
        end
    end

    // either edge of the button counts
    assign btn_change = btn_meta ^ btn_sync;

    // wrapping code counter
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            code_q <= `CN_SCALE_W'(`CN_SCALE_MIN);             // scaler 1
        end else if (btn_change) begin
            if (code_q == `CN_SCALE_W'(`CN_SCALE_MAX)) begin   // scaler 7 -> 1
                code_q <= `CN_SCALE_W'(`CN_SCALE_MIN);
            end else begin
                code_q <= code_q + 1'b1;
            end
        end
    end

    // two presses per multiplier step
    assign o_scaler = code_q >> 1;

endmodule

//--- design/drive_mixer.sv
`include "cn_drive_config.svh"

module drive_mixer
    import cn_drive_pkg::*;
(
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   i_clear,      // sim clear
    input  syn_currents_t          i_currents,
    input  logic [`CN_DATA_W-1:0]  i_gain,       // host gain on the afferent pair
    input  logic [`CN_SCALE_W-1:0] i_scaler,     // button multiplier
    output logic [`CN_DATA_W-1:0]  o_drive       // latched fixed-point drive
);

    logic [`CN_DATA_W-1:0] afferent_sum;     // Ia + II
    logic [`CN_DATA_W-1:0] afferent_gained;
    logic [`CN_DATA_W-1:0] afferent_term;    // gained and shifted into place
    logic [`CN_DATA_W-1:0] scaler_ext;
    logic [`CN_DATA_W-1:0] cortical_scaled;  // m1b times button scaler
    logic [`CN_DATA_W-1:0] drive_d;
    logic [`CN_DATA_W-1:0] drive_q;

    // spindle afferents share one gain
    assign afferent_sum    = i_currents.ia + i_currents.ii;
    assign afferent_gained = afferent_sum * i_gain;                  // low 32 bits kept
    assign afferent_term   = afferent_gained << `CN_DRIVE_SHIFT;

    // second cortical input follows the push button
    assign scaler_ext      = {{(`CN_DATA_W-`CN_SCALE_W){1'b0}}, i_scaler};
    assign cortical_scaled = i_currents.m1b * scaler_ext;

    // shift binds to the afferent term only, then the cortical terms add on
    assign drive_d = afferent_term + i_currents.m1a + cortical_scaled;

    // one latch per tick
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            drive_q <= '0;
        end else if (i_clear) begin
            drive_q <= '0;
        end else begin
            drive_q <= drive_d;       // wraps at 32 bits
        end
    end

    assign o_drive = drive_q;

endmodule

//--- design/cn_drive_top.sv
`include "cn_drive_config.svh"

module cn_drive_top
    import cn_drive_pkg::*;
(
    input  logic                   ep50trig,      // simulation tick
    input  logic                   reset_global,
    input  host_words_t            i_host_words,
    input  logic [`CN_TRIG_W-1:0]  i_trig,
    input  logic [`CN_HOST_W-1:0]  i_ctrl,        // control wire, one host word wide
    input  logic                   i_ext_reset,
    input  syn_spikes_t            i_spikes,
    input  logic                   i_button,
    output logic [`CN_DATA_W-1:0]  o_drive,
    output syn_currents_t          o_currents,
    output logic [`CN_SCALE_W-1:0] o_scaler,
    output logic [`CN_DATA_W-1:0]  o_gain,
    output logic [6:0]             o_led          // active low
);

    logic                   sim_clear;
    logic [`CN_DATA_W-1:0]  gain;
    logic [`CN_SCALE_W-1:0] scaler;
    syn_currents_t          currents;

    // host gain register and sim clear
    host_regs u_host_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_host_words (i_host_words),
        .i_trig       (i_trig),
        .i_ctrl       (i_ctrl),
        .i_ext_reset  (i_ext_reset),
        .o_gain       (gain),
        .o_sim_clear  (sim_clear)
    );

    // one simple synapse per presynaptic source
    synapse_decay u_syn_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_clear      (sim_clear),
        .i_spike      (i_spikes.ia),
        .o_current    (currents.ia)
    );

    synapse_decay u_syn_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_clear      (sim_clear),
        .i_spike      (i_spikes.ii),
        .o_current    (currents.ii)
    );

    synapse_decay u_syn_m1a (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_clear      (sim_clear),
        .i_spike      (i_spikes.m1a),
        .o_current    (currents.m1a)
    );

    synapse_decay u_syn_m1b (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_clear      (sim_clear),
        .i_spike      (i_spikes.m1b),
        .o_current    (currents.m1b)
    );

    // push-button multiplier for m1b
    button_scaler u_button_scaler (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_button     (i_button),
        .o_scaler     (scaler)
    );

    // drive lags the currents by one tick
    drive_mixer u_drive_mixer (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_clear      (sim_clear),
        .i_currents   (currents),
        .i_gain       (gain),
        .i_scaler     (scaler),
        .o_drive      (o_drive)
    );

    assign o_currents = currents;
    assign o_scaler   = scaler;
    assign o_gain     = gain;

    // status LEDs, lit when the source is high
    assign o_led[0]   = ~sim_clear;
    assign o_led[1]   = ~i_spikes.ia;
    assign o_led[2]   = ~i_spikes.ii;
    assign o_led[3]   = ~i_spikes.m1a;
    assign o_led[6:4] = ~scaler[2:0];   // binary multiplier

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS    = 40,   // ep50trig period
    parameter int RESET_CYCLES = 16    // edges with reset_global held high
) (
    output logic ep50trig,
    output logic reset_global
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        ep50trig = 1'b0;
        forever #(PERIOD_NS / 2) ep50trig = ~ep50trig;
    end

    // release just after an edge so no flop sees reset and clock together
    initial begin
        reset_global = 1'b1;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        #2 reset_global = 1'b0;
    end

endmodule

//--- tb/tb_cn_drive_top.sv
`include "cn_drive_config.svh"

module tb_cn_drive_top
    import cn_drive_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // phase lengths in cycles, they also size the timeout
    localparam int RESET_CYCLES   = 16;
    localparam int SETTLE_CYCLES  = 4;
    localparam int DECAY_CYCLES   = 20;
    localparam int SPIKE_CYCLES   = 4 * (1 + DECAY_CYCLES);
    localparam int GAIN_CYCLES    = 6;
    localparam int BUTTON_TOGGLES = 14;   // full walk plus the wrap to 1
    localparam int BUTTON_HOLD    = 4;    // longer than sync plus step
    localparam int RANDOM_CYCLES  = 800;
    localparam int CLEAR_HOLD     = 8;
    localparam int CLEAR_GAP      = 4;
    localparam int STIM_CYCLES    = RESET_CYCLES + SETTLE_CYCLES + SPIKE_CYCLES + GAIN_CYCLES
                                  + BUTTON_TOGGLES * BUTTON_HOLD + RANDOM_CYCLES
                                  + 2 * (CLEAR_HOLD + CLEAR_GAP);
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    localparam logic [`CN_TRIG_W-1:0] GAIN_MASK = `CN_TRIG_W'(1) << TRIG_SYN_GAIN;

    logic                   ep50trig;
    logic                   reset_global;
    host_words_t            i_host_words;
    logic [`CN_TRIG_W-1:0]  i_trig;
    logic [`CN_HOST_W-1:0]  i_ctrl;
    logic                   i_ext_reset;
    syn_spikes_t            i_spikes;
    logic                   i_button;
    logic [`CN_DATA_W-1:0]  o_drive;
    syn_currents_t          o_currents;
    logic [`CN_SCALE_W-1:0] o_scaler;
    logic [`CN_DATA_W-1:0]  o_gain;
    logic [6:0]             o_led;

    // reference model state, updated on the same edges as the DUT
    syn_currents_t          ref_cur;
    logic [`CN_DATA_W-1:0]  ref_gain;
    logic [`CN_DATA_W-1:0]  ref_drive;
    logic                   ref_clear;
    logic                   ref_btn_meta;
    logic                   ref_btn_sync;
    logic [`CN_SCALE_W-1:0] ref_code;     // 2..14, halved gives the multiplier
    logic [`CN_SCALE_W-1:0] ref_scaler;

    integer seed = 32'h5be3_354e;
    int     cycle_count = 0;
    int     n_loads = 0;    // events the stimulus must reach
    int     n_kicks = 0;
    int     n_wraps = 0;
    int     n_clears = 0;

    tb_clock #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .ep50trig     (ep50trig),
        .reset_global (reset_global)
    );

    cn_drive_top u_dut (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_host_words (i_host_words),
        .i_trig       (i_trig),
        .i_ctrl       (i_ctrl),
        .i_ext_reset  (i_ext_reset),
        .i_spikes     (i_spikes),
        .i_button     (i_button),
        .o_drive      (o_drive),
        .o_currents   (o_currents),
        .o_scaler     (o_scaler),
        .o_gain       (o_gain),
        .o_led        (o_led)
    );

    // leak by a right shift, then add the weight on a spike
    function automatic logic [`CN_DATA_W-1:0] next_current(input logic [`CN_DATA_W-1:0] cur,
                                                           input logic spike);
        logic [`CN_DATA_W-1:0] step;
        step = spike ? `CN_DATA_W'(`CN_SYN_WEIGHT) : '0;
        return cur - (cur >> `CN_SYN_TAU_SHIFT) + step;
    endfunction

    assign ref_scaler = ref_code >> 1;   // two changes per multiplier step

    always @(posedge ep50trig or posedge reset_global) begin
        logic [`CN_DATA_W-1:0] afferent;
        logic [`CN_DATA_W-1:0] scaler_ext;
        if (reset_global) begin
            ref_cur      <= '0;
            ref_gain     <= `CN_DATA_W'(`CN_GAIN_RESET);
            ref_drive    <= '0;
            ref_clear    <= 1'b0;
            ref_btn_meta <= 1'b0;
            ref_btn_sync <= 1'b0;
            ref_code     <= `CN_SCALE_W'(`CN_SCALE_MIN);
        end else begin
            afferent   = (ref_cur.ia + ref_cur.ii) * ref_gain;   // low 32 bits
            scaler_ext = `CN_DATA_W'(ref_scaler);
            ref_clear <= i_ext_reset | i_ctrl[`CN_CTRL_SIM_RESET];
            if (i_trig[TRIG_SYN_GAIN]) begin
                ref_gain <= {i_host_words.hi, i_host_words.lo};
            end
            ref_btn_meta <= i_button;
            ref_btn_sync <= ref_btn_meta;
            if (ref_btn_meta != ref_btn_sync) begin
                if (ref_code == `CN_SCALE_W'(`CN_SCALE_MAX)) begin
                    ref_code <= `CN_SCALE_W'(`CN_SCALE_MIN);   // 7 back to 1
                end else begin
                    ref_code <= ref_code + 4'd1;
                end
            end
            if (ref_clear) begin
                ref_cur   <= '0;
                ref_drive <= '0;
            end else begin
                ref_cur.ia  <= next_current(ref_cur.ia, i_spikes.ia);
                ref_cur.ii  <= next_current(ref_cur.ii, i_spikes.ii);
                ref_cur.m1a <= next_current(ref_cur.m1a, i_spikes.m1a);
                ref_cur.m1b <= next_current(ref_cur.m1b, i_spikes.m1b);
                ref_drive   <= (afferent << `CN_DRIVE_SHIFT) + ref_cur.m1a
                               + ref_cur.m1b * scaler_ext;
            end
        end
    end

    // how far the stimulus got
    always @(posedge ep50trig) begin
        cycle_count <= cycle_count + 1;
        if (!reset_global) begin
            if (i_trig[TRIG_SYN_GAIN]) n_loads <= n_loads + 1;
            if (i_spikes != '0 && !ref_clear) n_kicks <= n_kicks + 1;
            if (ref_clear) n_clears <= n_clears + 1;
            if (ref_btn_meta != ref_btn_sync && ref_code == `CN_SCALE_W'(`CN_SCALE_MAX)) begin
                n_wraps <= n_wraps + 1;
            end
        end
    end

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t ns: %s", $time, what);
        $display("test failed");
        $fatal(1, "output check failed");
    endtask

    a_after_reset: assert property (@(posedge ep50trig) disable iff (reset_global)
        $past(reset_global) |-> (o_drive == '0 && o_currents == '0 && o_scaler == 4'd1
                                 && o_gain == `CN_DATA_W'(`CN_GAIN_RESET)))
        else report_mismatch("outputs after reset are not the reset defaults");
    a_currents: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_currents == ref_cur)
        else report_mismatch("o_currents differs from the synapse model");
    a_gain: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_gain == ref_gain)
        else report_mismatch("o_gain differs from the model");
    a_gain_load: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_trig[TRIG_SYN_GAIN] |=> o_gain == $past({i_host_words.hi, i_host_words.lo}))
        else report_mismatch("gain strobe did not load hi above lo");
    a_gain_hold: assert property (@(posedge ep50trig) disable iff (reset_global)
        !i_trig[TRIG_SYN_GAIN] |=> o_gain == $past(ref_gain))
        else report_mismatch("gain moved without its strobe");
    a_scaler: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_scaler == ref_scaler)
        else report_mismatch("o_scaler differs from the button model");
    a_drive: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_drive == ref_drive)
        else report_mismatch("o_drive differs from the mixer model");
    a_decay_ia: assert property (@(posedge ep50trig) disable iff (reset_global)
        !i_spikes.ia |=> o_currents.ia <= $past(ref_cur.ia))
        else report_mismatch("ia current rose without a spike");
    a_decay_m1b: assert property (@(posedge ep50trig) disable iff (reset_global)
        !i_spikes.m1b |=> o_currents.m1b <= $past(ref_cur.m1b))
        else report_mismatch("m1b current rose without a spike");
    a_clear: assert property (@(posedge ep50trig) disable iff (reset_global)
        (i_ext_reset || i_ctrl[`CN_CTRL_SIM_RESET]) |-> ##2 (o_currents == '0 && o_drive == '0))
        else report_mismatch("sim clear did not zero currents and drive");
    a_led: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_led == ~{ref_scaler[2:0], i_spikes.m1a, i_spikes.ii, i_spikes.ia, ref_clear})
        else report_mismatch("o_led does not mirror its inverted sources");

    // inputs change 2 ns after the edge
    task automatic tick();
        @(posedge ep50trig);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic fire_spike(input int src);
        syn_spikes_t s;
        s = '0;
        case (src)
            0:       s.ia  = 1'b1;
            1:       s.ii  = 1'b1;
            2:       s.m1a = 1'b1;
            default: s.m1b = 1'b1;
        endcase
        i_spikes = s;
        tick();
        i_spikes = '0;
    endtask

    task automatic strobe_trig(input logic [`CN_TRIG_W-1:0] bits,
                               input logic [`CN_HOST_W-1:0] hi,
                               input logic [`CN_HOST_W-1:0] lo);
        i_trig          = bits;
        i_host_words.hi = hi;
        i_host_words.lo = lo;
        tick();
        i_trig = '0;
    endtask

    task automatic run_random(input int n);
        logic [31:0] rnd;
        repeat (n) begin
            rnd      = $random(seed);
            i_spikes = syn_spikes_t'(rnd[3:0] & rnd[7:4]);   // each about 1 in 4
            if (rnd[12:8] == 5'd0) begin
                i_trig = GAIN_MASK;
                {i_host_words.hi, i_host_words.lo} = $random(seed);
            end else begin
                i_trig = rnd[31:16] & ~GAIN_MASK;   // noise on the other strobes
            end
            if (rnd[15:13] == 3'd0) i_button = ~i_button;
            tick();
        end
        i_spikes = '0;
        i_trig   = '0;
    endtask

    initial begin
        i_host_words = '0;
        i_trig       = '0;
        i_ctrl       = '0;
        i_ext_reset  = 1'b0;
        i_spikes     = '0;
        i_button     = 1'b0;
        @(negedge reset_global);
        idle(SETTLE_CYCLES);
        for (int src = 0; src < 4; src++) begin
            fire_spike(src);
            idle(DECAY_CYCLES);   // watch the leak
        end
        strobe_trig(~GAIN_MASK, 16'hdead, 16'hbeef);   // all bits but the gain
        idle(1);
        strobe_trig(GAIN_MASK, 16'h0001, 16'h0002);     // word order check
        idle(1);
        strobe_trig(GAIN_MASK, 16'h0000, 16'h0003);
        idle(1);
        for (int t = 0; t < BUTTON_TOGGLES; t++) begin
            i_button = ~i_button;
            idle(BUTTON_HOLD);
        end
        run_random(RANDOM_CYCLES);
        i_ext_reset = 1'b1;
        run_random(CLEAR_HOLD);   // spikes keep arriving while cleared
        i_ext_reset = 1'b0;
        idle(CLEAR_GAP);
        i_ctrl[`CN_CTRL_SIM_RESET] = 1'b1;
        run_random(CLEAR_HOLD);
        i_ctrl = '0;
        idle(CLEAR_GAP);
        if (n_loads > 0 && n_kicks > 0 && n_wraps > 0 && n_clears > 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("stimulus missed a behavior: loads %0d kicks %0d wraps %0d clears %0d",
                     n_loads, n_kicks, n_wraps, n_clears);
            $display("test failed");
            $fatal(1, "stimulus incomplete");
        end
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, stimulus never finished", cycle_count);
        $display("test failed");
        $fatal(1, "timeout");
    end

endmodule

//--- cn_drive_top.f
+incdir+design
design/cn_drive_pkg.sv
design/host_regs.sv
design/synapse_decay.sv
design/button_scaler.sv
design/drive_mixer.sv
design/cn_drive_top.sv
tb/tb_clock.sv
tb/tb_cn_drive_top.sv

//--- Makefile
# Verilator build and run of the cn_drive testbench
# every setting below can be overridden, e.g. make run JOBS=8

VERILATOR ?= verilator
TOP       ?= tb_cn_drive_top
FLIST     ?= cn_drive_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
EXTRA     ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FLIST))
HDRS    := $(wildcard design/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# the simulator exits non-zero on any $fatal, so make fails with it
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
